/* src/dram_pkg.sv */
package dram_pkg;

    // address fields, bank on top
    localparam int BA_WIDTH   = 2;
    localparam int RA_WIDTH   = 8;
    localparam int CA_WIDTH   = 6;
    localparam int ADDR_WIDTH = BA_WIDTH + RA_WIDTH + CA_WIDTH;

    localparam int T_WIDTH    = 5;   // all timing values and counters

    typedef enum logic [2:0] {
        CMD_NOP,
        CMD_ACT,
        CMD_RD,
        CMD_WR,
        CMD_PRE,
        CMD_REF
    } cmd_op_e;

    // host side, held until ready
    typedef struct packed {
        logic                  valid;
        logic                  wr;
        logic [ADDR_WIDTH-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                act;
        logic                rd;
        logic                wr;
        logic                pre;
        logic                refresh;
        logic [RA_WIDTH-1:0] ra;
        logic [CA_WIDTH-1:0] ca;
    } bank_req_t;

    typedef struct packed {
        logic act;
        logic rd;
        logic wr;
        logic pre;
        logic refresh;
    } bank_gnt_t;

    typedef struct packed {
        cmd_op_e             op;
        logic [BA_WIDTH-1:0] ba;
        logic [RA_WIDTH-1:0] ra;
        logic [CA_WIDTH-1:0] ca;
    } dram_cmd_t;

    // in clock cycles, each at least 1
    typedef struct packed {
        logic [T_WIDTH-1:0] t_rcd;
        logic [T_WIDTH-1:0] t_rp;
        logic [T_WIDTH-1:0] t_ras;
        logic [T_WIDTH-1:0] t_rfc;
        logic [T_WIDTH-1:0] t_rtp;
        logic [T_WIDTH-1:0] t_wtp;
    } timing_t;

endpackage

/* src/timing_cntr.sv */
`timescale 1ns/1ps

module timing_cntr
    import dram_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_i,
    input  logic [T_WIDTH-1:0] load_value_i,
    output logic               met_o
);

    logic [T_WIDTH-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load_i) begin
            cnt <= load_value_i - 1'b1;  // grant cycle counts as the first one
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // zero means the constraint no longer blocks
    assign met_o = (cnt == '0);

endmodule

/* src/bank_ctrl.sv */
`timescale 1ns/1ps

module bank_ctrl
    import dram_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  logic                wr_i,
    input  logic [RA_WIDTH-1:0] ra_i,
    input  logic [CA_WIDTH-1:0] ca_i,
    input  timing_t             timing_i,
    output logic                ready_o,
    input  logic                ref_req_i,
    output logic                ref_gnt_o,
    output bank_req_t           sched_req_o,
    input  bank_gnt_t           sched_gnt_i
);

    typedef enum logic {
        BANK_CLOSED,
        BANK_OPEN
    } bank_state_e;

    bank_state_e         state;
    logic [RA_WIDTH-1:0] open_ra;
    logic                row_hit;
    logic                rcd_met, rp_met, ras_met, rfc_met, rtp_met, wtp_met;

    assign row_hit = (open_ra == ra_i);

    // request flags depend on state and timers only, never on the grant
    always_comb begin
        sched_req_o    = '0;
        sched_req_o.ra = ra_i;
        sched_req_o.ca = ca_i;
        case (state)
            BANK_CLOSED: begin
                if (rp_met && rfc_met) begin
                    if (ref_req_i) begin
                        sched_req_o.refresh = 1'b1;  // refresh wins over a new access
                    end else if (valid_i) begin
                        sched_req_o.act = 1'b1;
                    end
                end
            end
            BANK_OPEN: begin
                if (valid_i) begin
                    if (row_hit) begin
                        if (rcd_met) begin
                            sched_req_o.rd = !wr_i;
                            sched_req_o.wr = wr_i;
                        end
                    end else if (ras_met && rtp_met && wtp_met) begin
                        sched_req_o.pre = 1'b1;  // row miss, close first
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= BANK_CLOSED;
        end else if (sched_gnt_i.act) begin
            state <= BANK_OPEN;
        end else if (sched_gnt_i.pre) begin
            state <= BANK_CLOSED;
        end
    end

    always_ff @(posedge clk) begin
        if (sched_gnt_i.act) begin
            open_ra <= ra_i;
        end
    end

    assign ready_o   = sched_gnt_i.rd | sched_gnt_i.wr;  // access issued this cycle
    assign ref_gnt_o = sched_gnt_i.refresh;

    timing_cntr u_rcd_cnt (
        .clk(clk), .rst_n(rst_n),
        .load_i(sched_gnt_i.act), .load_value_i(timing_i.t_rcd), .met_o(rcd_met)
    );
    timing_cntr u_rp_cnt (
        .clk(clk), .rst_n(rst_n),
        .load_i(sched_gnt_i.pre), .load_value_i(timing_i.t_rp), .met_o(rp_met)
    );
    timing_cntr u_ras_cnt (
        .clk(clk), .rst_n(rst_n),
        .load_i(sched_gnt_i.act), .load_value_i(timing_i.t_ras), .met_o(ras_met)
    );
    timing_cntr u_rfc_cnt (
        .clk(clk), .rst_n(rst_n),
        .load_i(sched_gnt_i.refresh), .load_value_i(timing_i.t_rfc), .met_o(rfc_met)
    );
    timing_cntr u_rtp_cnt (
        .clk(clk), .rst_n(rst_n),
        .load_i(sched_gnt_i.rd), .load_value_i(timing_i.t_rtp), .met_o(rtp_met)
    );
    timing_cntr u_wtp_cnt (
        .clk(clk), .rst_n(rst_n),
        .load_i(sched_gnt_i.wr), .load_value_i(timing_i.t_wtp), .met_o(wtp_met)
    );

    // the scheduler relies on a single outstanding command per bank
    a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sched_req_o.act, sched_req_o.rd, sched_req_o.wr,
                  sched_req_o.pre, sched_req_o.refresh}));

endmodule

/* src/addr_decoder.sv */
`timescale 1ns/1ps

module addr_decoder
    import dram_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  mem_req_t              req_i,
    output logic                  ready_o,
    output logic [NUM_BANKS-1:0]  bank_valid_o,
    output logic                  bank_wr_o,
    output logic [RA_WIDTH-1:0]   bank_ra_o,
    output logic [CA_WIDTH-1:0]   bank_ca_o,
    input  logic [NUM_BANKS-1:0]  bank_ready_i
);

    logic [BA_WIDTH-1:0]  ba;
    logic [NUM_BANKS-1:0] bank_sel;

    assign ba        = req_i.addr[ADDR_WIDTH-1 -: BA_WIDTH];
    assign bank_ra_o = req_i.addr[CA_WIDTH +: RA_WIDTH];
    assign bank_ca_o = req_i.addr[CA_WIDTH-1:0];
    assign bank_wr_o = req_i.wr;  // shared, only the selected bank acts on it

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_sel[i] = (ba == BA_WIDTH'(i));
        end
    end

    assign bank_valid_o = bank_sel & {NUM_BANKS{req_i.valid}};

    // only the addressed bank's ready counts
    assign ready_o = |(bank_sel & bank_ready_i);

    // a bank must not complete an access nobody asked for
    always_comb begin
        a_ready_valid: assert (!ready_o || req_i.valid)
            else $error("ready_o without a valid request");
    end

endmodule

/* src/cmd_scheduler.sv */
`timescale 1ns/1ps

module cmd_scheduler
    import dram_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  bank_req_t bank_req_i [NUM_BANKS],
    output bank_gnt_t bank_gnt_o [NUM_BANKS],
    output dram_cmd_t cmd_o
);

    localparam int PTR_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    logic [PTR_W-1:0]           ptr;
    logic [PTR_W-1:0]           gnt_idx;
    logic                       gnt_vld;
    logic [NUM_BANKS-1:0][4:0]  req_flags;
    logic [NUM_BANKS-1:0][4:0]  gnt_flags;
    logic [NUM_BANKS-1:0]       any_req;
    logic [NUM_BANKS-1:0]       gnt_any;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            req_flags[i] = {bank_req_i[i].act, bank_req_i[i].rd, bank_req_i[i].wr,
                            bank_req_i[i].pre, bank_req_i[i].refresh};
            any_req[i]   = |req_flags[i];
        end
    end

    // first requesting bank from ptr onward
    always_comb begin
        int idx;
        gnt_vld = 1'b0;
        gnt_idx = ptr;
        for (int k = 0; k < NUM_BANKS; k++) begin
            idx = (int'(ptr) + k) % NUM_BANKS;
            if (!gnt_vld && any_req[idx]) begin
                gnt_vld = 1'b1;
                gnt_idx = PTR_W'(idx);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_gnt_o[i] = '0;
        end
        if (gnt_vld) begin
            bank_gnt_o[gnt_idx].act     = bank_req_i[gnt_idx].act;
            bank_gnt_o[gnt_idx].rd      = bank_req_i[gnt_idx].rd;
            bank_gnt_o[gnt_idx].wr      = bank_req_i[gnt_idx].wr;
            bank_gnt_o[gnt_idx].pre     = bank_req_i[gnt_idx].pre;
            bank_gnt_o[gnt_idx].refresh = bank_req_i[gnt_idx].refresh;
        end
    end

    always_comb begin
        cmd_o = '{op: CMD_NOP, ba: '0, ra: '0, ca: '0};
        if (gnt_vld) begin
            cmd_o.ba = BA_WIDTH'(gnt_idx);
            cmd_o.ra = bank_req_i[gnt_idx].ra;
            cmd_o.ca = bank_req_i[gnt_idx].ca;
            if (bank_req_i[gnt_idx].refresh)  cmd_o.op = CMD_REF;
            else if (bank_req_i[gnt_idx].pre) cmd_o.op = CMD_PRE;
            else if (bank_req_i[gnt_idx].act) cmd_o.op = CMD_ACT;
            else if (bank_req_i[gnt_idx].rd)  cmd_o.op = CMD_RD;
            else                              cmd_o.op = CMD_WR;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (gnt_vld) begin
            ptr <= (int'(gnt_idx) == NUM_BANKS - 1) ? '0 : gnt_idx + 1'b1;  // bank after winner
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            gnt_flags[i] = {bank_gnt_o[i].act, bank_gnt_o[i].rd, bank_gnt_o[i].wr,
                            bank_gnt_o[i].pre, bank_gnt_o[i].refresh};
            gnt_any[i]   = |gnt_flags[i];
        end
    end

    a_gnt_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gnt_any) && ((gnt_flags & ~req_flags) == '0));

endmodule

/* src/dram_bank_top.sv */
`timescale 1ns/1ps

module dram_bank_top
    import dram_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mem_req_t             req_i,
    output logic                 ready_o,
    input  timing_t              timing_i,
    input  logic [NUM_BANKS-1:0] pb_ref_req_i,
    output logic [NUM_BANKS-1:0] pb_ref_gnt_o,
    output dram_cmd_t            cmd_o
);

    logic [NUM_BANKS-1:0] bank_valid;
    logic [NUM_BANKS-1:0] bank_ready;
    logic                 bank_wr;
    logic [RA_WIDTH-1:0]  bank_ra;
    logic [CA_WIDTH-1:0]  bank_ca;
    bank_req_t            bank_req [NUM_BANKS];
    bank_gnt_t            bank_gnt [NUM_BANKS];

    addr_decoder #(.NUM_BANKS(NUM_BANKS)) u_addr_decoder (
        .req_i(req_i), .ready_o(ready_o),
        .bank_valid_o(bank_valid), .bank_wr_o(bank_wr),
        .bank_ra_o(bank_ra), .bank_ca_o(bank_ca),
        .bank_ready_i(bank_ready)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bank_ctrl u_bank_ctrl (
            .clk(clk), .rst_n(rst_n),
            .valid_i(bank_valid[b]), .wr_i(bank_wr), .ra_i(bank_ra), .ca_i(bank_ca),
            .timing_i(timing_i), .ready_o(bank_ready[b]),
            .ref_req_i(pb_ref_req_i[b]), .ref_gnt_o(pb_ref_gnt_o[b]),
            .sched_req_o(bank_req[b]), .sched_gnt_i(bank_gnt[b])
        );
    end

    cmd_scheduler #(.NUM_BANKS(NUM_BANKS)) u_cmd_scheduler (
        .clk(clk), .rst_n(rst_n),
        .bank_req_i(bank_req), .bank_gnt_o(bank_gnt),
        .cmd_o(cmd_o)
    );

endmodule

/* verification/dram_bank_tb.sv */
`timescale 1ns/1ps

module dram_bank_tb
    import dram_pkg::*;
();

    localparam int NUM_BANKS  = 4;
    localparam int N_ENTRIES  = 15;
    localparam int MAX_CYCLES = N_ENTRIES * 40;

    localparam timing_t TIMING = '{t_rcd: 5'd3, t_rp: 5'd3, t_ras: 5'd6,
                                   t_rfc: 5'd8, t_rtp: 5'd2, t_wtp: 5'd4};

    typedef enum logic {
        K_ACCESS,
        K_REFRESH
    } kind_e;

    typedef struct packed {
        kind_e               kind;
        logic [BA_WIDTH-1:0] bank;
        logic [RA_WIDTH-1:0] row;
        logic [CA_WIDTH-1:0] col;
        logic                wr;
    } entry_t;

    // kind, bank, row, col, wr
    localparam entry_t TBL [N_ENTRIES] = '{
        '{K_ACCESS,  2'd0, 8'd10, 6'd5,  1'b0},  // closed bank
        '{K_ACCESS,  2'd0, 8'd10, 6'd6,  1'b1},  // row hit
        '{K_ACCESS,  2'd0, 8'd10, 6'd7,  1'b0},
        '{K_ACCESS,  2'd0, 8'd20, 6'd1,  1'b1},  // row miss
        '{K_REFRESH, 2'd1, 8'd0,  6'd0,  1'b0},
        '{K_ACCESS,  2'd1, 8'd33, 6'd2,  1'b0},  // act after tRFC
        '{K_ACCESS,  2'd2, 8'd5,  6'd3,  1'b1},
        '{K_ACCESS,  2'd1, 8'd33, 6'd4,  1'b1},
        '{K_ACCESS,  2'd2, 8'd6,  6'd9,  1'b0},  // miss right after a write
        '{K_REFRESH, 2'd3, 8'd0,  6'd0,  1'b0},
        '{K_REFRESH, 2'd3, 8'd0,  6'd0,  1'b0},  // back to back refresh
        '{K_ACCESS,  2'd3, 8'd7,  6'd10, 1'b0},
        '{K_ACCESS,  2'd3, 8'd8,  6'd12, 1'b1},
        '{K_ACCESS,  2'd0, 8'd20, 6'd11, 1'b0},
        '{K_ACCESS,  2'd0, 8'd30, 6'd13, 1'b1}   // miss right after a read
    };

    logic                 clk;
    logic                 rst_n;
    mem_req_t             req_i;
    logic                 ready_o;
    timing_t              timing_i;
    logic [NUM_BANKS-1:0] pb_ref_req_i;
    logic [NUM_BANKS-1:0] pb_ref_gnt_o;
    dram_cmd_t            cmd_o;

    int                  cyc = 0;
    int                  cur;
    logic                active;
    int                  n_errors = 0;
    // reference model, one slot per bank
    logic                bank_open [NUM_BANKS];
    logic [RA_WIDTH-1:0] open_row  [NUM_BANKS];
    int                  last_act  [NUM_BANKS];
    int                  last_pre  [NUM_BANKS];
    int                  last_ref  [NUM_BANKS];
    int                  last_rd   [NUM_BANKS];
    int                  last_wr   [NUM_BANKS];

    dram_bank_top #(.NUM_BANKS(NUM_BANKS)) uut (
        .clk(clk), .rst_n(rst_n),
        .req_i(req_i), .ready_o(ready_o), .timing_i(timing_i),
        .pb_ref_req_i(pb_ref_req_i), .pb_ref_gnt_o(pb_ref_gnt_o),
        .cmd_o(cmd_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(string name, int expected, int actual);
        n_errors++;
        $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1, "mismatch");
    endtask

    task automatic report_spacing(string name, int t_min, int actual);
        n_errors++;
        $display("Fail %s: expected at least %0d cycles, actual %0d", name, t_min, actual);
        $display("STATUS: FAIL");
        $fatal(1, "timing violation");
    endtask

    task automatic report_fault(string what);
        n_errors++;
        $display("Error: %s", what);
        $display("STATUS: FAIL");
        $fatal(1, "unexpected command");
    endtask

    task automatic check_spacing(string name, int since, int t_min);
        assert (cyc - since >= t_min) else report_spacing(name, t_min, cyc - since);
    endtask

    // what the bank should issue next for the current entry
    function automatic cmd_op_e expected_op(entry_t e);
        if (e.kind == K_REFRESH) begin
            return bank_open[e.bank] ? CMD_NOP : CMD_REF;
        end else if (!bank_open[e.bank]) begin
            return CMD_ACT;
        end else if (open_row[e.bank] == e.row) begin
            return e.wr ? CMD_WR : CMD_RD;
        end else begin
            return CMD_PRE;
        end
    endfunction

    task automatic reset_model();
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_open[b] = 1'b0;
            open_row[b]  = '0;
            last_act[b]  = -100;  // far enough back to block nothing
            last_pre[b]  = -100;
            last_ref[b]  = -100;
            last_rd[b]   = -100;
            last_wr[b]   = -100;
        end
    endtask

    task automatic check_command();
        entry_t               e;
        cmd_op_e              exp_op;
        int                   b;
        string                tag;
        logic [NUM_BANKS-1:0] exp_gnt;
        e   = TBL[cur];
        b   = int'(cmd_o.ba);
        tag = $sformatf("entry %0d", cur);
        if (cmd_o.op == CMD_NOP) begin
            assert (!ready_o) else report_fault({tag, ": ready_o pulsed without RD or WR"});
            assert (pb_ref_gnt_o == '0)
                else report_fault({tag, ": refresh grant without CMD_REF"});
        end else begin
            assert (active) else report_fault("command on the bus with no request pending");
            assert (b == int'(e.bank)) else report_mismatch({tag, " bank"}, e.bank, b);
            exp_op  = expected_op(e);
            exp_gnt = (exp_op == CMD_REF) ? (NUM_BANKS'(1) << e.bank) : '0;
            assert (cmd_o.op == exp_op) else report_mismatch({tag, " opcode"}, exp_op, cmd_o.op);
            assert (ready_o == (exp_op inside {CMD_RD, CMD_WR}))
                else report_mismatch({tag, " ready_o"}, (exp_op inside {CMD_RD, CMD_WR}),
                                     ready_o);
            assert (pb_ref_gnt_o == exp_gnt)
                else report_mismatch({tag, " pb_ref_gnt_o"}, exp_gnt, pb_ref_gnt_o);
            case (cmd_o.op)
                CMD_ACT: begin
                    assert (cmd_o.ra == e.row) else report_mismatch({tag, " row"}, e.row, cmd_o.ra);
                    check_spacing({tag, " tRP"}, last_pre[b], TIMING.t_rp);
                    check_spacing({tag, " tRFC"}, last_ref[b], TIMING.t_rfc);
                    bank_open[b] = 1'b1;
                    open_row[b]  = cmd_o.ra;
                    last_act[b]  = cyc;
                end
                CMD_RD, CMD_WR: begin
                    assert (cmd_o.ca == e.col) else report_mismatch({tag, " col"}, e.col, cmd_o.ca);
                    check_spacing({tag, " tRCD"}, last_act[b], TIMING.t_rcd);
                    if (cmd_o.op == CMD_RD) last_rd[b] = cyc;
                    else last_wr[b] = cyc;
                end
                CMD_PRE: begin
                    check_spacing({tag, " tRAS"}, last_act[b], TIMING.t_ras);
                    check_spacing({tag, " tRTP"}, last_rd[b], TIMING.t_rtp);
                    check_spacing({tag, " tWTP"}, last_wr[b], TIMING.t_wtp);
                    bank_open[b] = 1'b0;
                    last_pre[b]  = cyc;
                end
                CMD_REF: begin
                    check_spacing({tag, " tRP"}, last_pre[b], TIMING.t_rp);
                    check_spacing({tag, " tRFC"}, last_ref[b], TIMING.t_rfc);
                    last_ref[b] = cyc;
                end
                default: ;
            endcase
        end
    endtask

    // monitor samples between edges, outputs settled
    always @(negedge clk) begin
        if (!rst_n) reset_model();
        else check_command();
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Error: timeout, table not finished within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic apply_entry(entry_t e);
        mem_req_t r;
        r = '0;
        if (e.kind == K_ACCESS) begin
            r.valid = 1'b1;
            r.wr    = e.wr;
            r.addr  = {e.bank, e.row, e.col};
        end
        req_i        <= r;
        pb_ref_req_i <= (e.kind == K_REFRESH) ? (NUM_BANKS'(1) << e.bank) : '0;
    endtask

    function automatic logic entry_done(entry_t e);
        return (e.kind == K_ACCESS) ? ready_o : pb_ref_gnt_o[e.bank];
    endfunction

    initial begin
        rst_n        = 1'b0;
        req_i        = '0;
        timing_i     = TIMING;
        pb_ref_req_i = '0;
        active       = 1'b0;
        cur          = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_ENTRIES; i++) begin
            @(posedge clk);
            cur    = i;
            active = 1'b1;
            apply_entry(TBL[i]);
            @(negedge clk);
            while (!entry_done(TBL[i])) @(negedge clk);  // held until ready or grant
        end
        @(posedge clk);
        active = 1'b0;
        req_i        <= '0;
        pb_ref_req_i <= '0;
        repeat (10) @(posedge clk);  // bus must stay quiet
        if (n_errors == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* dram_bank.f */
src/dram_pkg.sv
src/timing_cntr.sv
src/bank_ctrl.sv
src/addr_decoder.sv
src/cmd_scheduler.sv
src/dram_bank_top.sv
verification/dram_bank_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dram_bank_tb -f dram_bank.f -o dram_bank_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dram_bank_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi
echo "$out" | grep -qx "STATUS: PASS" || exit 1
exit 0
